// File: isa_pkg.sv
package isa_pkg;

   // machine word and register file geometry
   localparam int data_w    = 16;
   localparam int reg_sel_w = 3;
   localparam int num_regs  = 8;

   // jal and jalr write their return address here
   localparam logic [reg_sel_w-1:0] link_reg = 3'd7;

   // instruction field positions
   localparam int op_lsb = 11;
   localparam int op_w   = 5;
   localparam int rs_lsb = 8;
   localparam int rt_lsb = 5;
   localparam int rd_lsb = 2;
   localparam int fn_w   = 2;

   // opcodes, bits 15:11
   localparam logic [op_w-1:0] op_halt  = 5'b00000;
   localparam logic [op_w-1:0] op_nop   = 5'b00001;
   localparam logic [op_w-1:0] op_j     = 5'b00100;
   localparam logic [op_w-1:0] op_jr    = 5'b00101;
   localparam logic [op_w-1:0] op_jal   = 5'b00110;
   localparam logic [op_w-1:0] op_jalr  = 5'b00111;
   localparam logic [op_w-1:0] op_addi  = 5'b01000;
   localparam logic [op_w-1:0] op_subi  = 5'b01001;
   localparam logic [op_w-1:0] op_xori  = 5'b01010;
   localparam logic [op_w-1:0] op_andni = 5'b01011;
   localparam logic [op_w-1:0] op_beqz  = 5'b01100;
   localparam logic [op_w-1:0] op_bnez  = 5'b01101;
   localparam logic [op_w-1:0] op_bltz  = 5'b01110;
   localparam logic [op_w-1:0] op_bgez  = 5'b01111;
   localparam logic [op_w-1:0] op_st    = 5'b10000;
   localparam logic [op_w-1:0] op_ld    = 5'b10001;
   localparam logic [op_w-1:0] op_lbi   = 5'b11000;
   localparam logic [op_w-1:0] op_alu   = 5'b11011;

   // function field of the register-register alu group, bits 1:0
   localparam logic [fn_w-1:0] fn_add  = 2'b00;
   localparam logic [fn_w-1:0] fn_sub  = 2'b01;
   localparam logic [fn_w-1:0] fn_xor  = 2'b10;
   localparam logic [fn_w-1:0] fn_andn = 2'b11;

endpackage

// File: ctrl_pkg.sv
package ctrl_pkg;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_XOR    = 4'd2,
      ALU_ANDN   = 4'd3,
      // lbi passes the extended immediate straight through
      ALU_PASS_B = 4'd4
   } alu_op_t;

   typedef enum logic [1:0] {
      EXT_IMM5   = 2'd0,
      EXT_IMM8   = 2'd1,
      EXT_DISP11 = 2'd2,
      EXT_NONE   = 2'd3
   } ext_op_t;

   typedef enum logic [2:0] {
      BR_NONE = 3'd0,
      BR_BEQZ = 3'd1,
      BR_BNEZ = 3'd2,
      BR_BLTZ = 3'd3,
      BR_BGEZ = 3'd4,
      BR_JREL = 3'd5,
      BR_JREG = 3'd6
   } br_kind_t;

   // which instruction field names the destination
   typedef enum logic [1:0] {
      DST_RD = 2'd0,
      DST_RT = 2'd1,
      DST_RS = 2'd2,
      DST_R7 = 2'd3
   } dst_sel_t;

   typedef struct packed {
      alu_op_t  alu_op;
      logic     alu_src;
      ext_op_t  ext_op;
      logic     ext_sign;
      br_kind_t br_kind;
      dst_sel_t dst_sel;
      logic     reg_write;
      logic     mem_read;
      logic     mem_write;
      logic     mem_to_reg;
      logic     link;
      logic     halt;
      logic     excp;
   } ctrl_t;

endpackage

// File: hazard_if.sv
interface hazard_if
   import isa_pkg::*;
();

   // destinations of the two instructions ahead of decode
   logic [reg_sel_w-1:0] ex_rd;
   logic                 ex_wr;
   logic [reg_sel_w-1:0] mem_rd;
   logic                 mem_wr;

   modport src (
      output ex_rd, ex_wr, mem_rd, mem_wr
   );

   modport det (
      input ex_rd, ex_wr, mem_rd, mem_wr
   );

endinterface

// File: control.sv
module control
   import isa_pkg::*, ctrl_pkg::*;
(
   input  logic [data_w-1:0] inst,
   output ctrl_t             ctrl,
   output logic              uses_rs,
   output logic              uses_rt
);

   logic [op_w-1:0] opcode;
   logic [fn_w-1:0] funct;

   assign opcode = inst[op_lsb +: op_w];
   assign funct  = inst[fn_w-1:0];

   always_comb begin
      // defaults describe a nop
      ctrl          = '0;
      ctrl.alu_op   = ALU_ADD;
      ctrl.ext_op   = EXT_NONE;
      ctrl.br_kind  = BR_NONE;
      ctrl.dst_sel  = DST_RD;
      uses_rs       = 1'b0;
      uses_rt       = 1'b0;

      case (opcode)
         op_nop: begin
         end
         op_halt: begin
            ctrl.halt = 1'b1;
         end
         op_alu: begin
            case (funct)
               fn_add:  ctrl.alu_op = ALU_ADD;
               fn_sub:  ctrl.alu_op = ALU_SUB;
               fn_xor:  ctrl.alu_op = ALU_XOR;
               default: ctrl.alu_op = ALU_ANDN;
            endcase
            ctrl.reg_write = 1'b1;
            uses_rs        = 1'b1;
            uses_rt        = 1'b1;
         end
         op_addi, op_subi, op_xori, op_andni: begin
            case (opcode)
               op_addi: ctrl.alu_op = ALU_ADD;
               op_subi: ctrl.alu_op = ALU_SUB;
               op_xori: ctrl.alu_op = ALU_XOR;
               default: ctrl.alu_op = ALU_ANDN;
            endcase
            ctrl.alu_src   = 1'b1;
            ctrl.ext_op    = EXT_IMM5;
            // logic immediates are zero extended
            ctrl.ext_sign  = (opcode == op_addi) || (opcode == op_subi);
            ctrl.dst_sel   = DST_RT;
            ctrl.reg_write = 1'b1;
            uses_rs        = 1'b1;
         end
         op_ld, op_st: begin
            ctrl.alu_src  = 1'b1;
            ctrl.ext_op   = EXT_IMM5;
            ctrl.ext_sign = 1'b1;
            ctrl.dst_sel  = DST_RT;
            uses_rs       = 1'b1;
            if (opcode == op_ld) begin
               ctrl.mem_read   = 1'b1;
               ctrl.mem_to_reg = 1'b1;
               ctrl.reg_write  = 1'b1;
            end else begin
               // store data comes from the rt field
               ctrl.mem_write = 1'b1;
               uses_rt        = 1'b1;
            end
         end
         op_lbi: begin
            ctrl.alu_op    = ALU_PASS_B;
            ctrl.alu_src   = 1'b1;
            ctrl.ext_op    = EXT_IMM8;
            ctrl.ext_sign  = 1'b1;
            ctrl.dst_sel   = DST_RS;
            ctrl.reg_write = 1'b1;
         end
         op_beqz, op_bnez, op_bltz, op_bgez: begin
            case (opcode)
               op_beqz: ctrl.br_kind = BR_BEQZ;
               op_bnez: ctrl.br_kind = BR_BNEZ;
               op_bltz: ctrl.br_kind = BR_BLTZ;
               default: ctrl.br_kind = BR_BGEZ;
            endcase
            ctrl.ext_op   = EXT_IMM8;
            ctrl.ext_sign = 1'b1;
            uses_rs       = 1'b1;
         end
         op_j, op_jal: begin
            ctrl.br_kind   = BR_JREL;
            ctrl.ext_op    = EXT_DISP11;
            ctrl.ext_sign  = 1'b1;
            ctrl.link      = (opcode == op_jal);
            ctrl.reg_write = (opcode == op_jal);
            ctrl.dst_sel   = DST_R7;
         end
         op_jr, op_jalr: begin
            ctrl.br_kind   = BR_JREG;
            ctrl.ext_op    = EXT_IMM8;
            ctrl.ext_sign  = 1'b1;
            ctrl.link      = (opcode == op_jalr);
            ctrl.reg_write = (opcode == op_jalr);
            ctrl.dst_sel   = DST_R7;
            uses_rs        = 1'b1;
         end
         default: begin
            ctrl.excp = 1'b1;
         end
      endcase
   end

endmodule

// File: imm_extend.sv
module imm_extend
   import isa_pkg::*, ctrl_pkg::*;
(
   input  logic [data_w-1:0] inst,
   input  ext_op_t           ext_op,
   input  logic              ext_sign,
   output logic [data_w-1:0] imm
);

   logic fill5;
   logic fill8;
   logic fill11;

   // sign bit of each field, forced low for zero extension
   assign fill5  = ext_sign & inst[4];
   assign fill8  = ext_sign & inst[7];
   assign fill11 = ext_sign & inst[10];

   always_comb begin
      case (ext_op)
         EXT_IMM5:   imm = {{(data_w-5){fill5}}, inst[4:0]};
         EXT_IMM8:   imm = {{(data_w-8){fill8}}, inst[7:0]};
         EXT_DISP11: imm = {{(data_w-11){fill11}}, inst[10:0]};
         default:    imm = '0;
      endcase
   end

   // an unknown immediate would corrupt the alu operand or the target
   always_comb begin
      if (ext_op != EXT_NONE) begin
         assert final (!$isunknown(imm))
            else $error("imm_extend: unknown immediate for ext_op %0d", ext_op);
      end
   end

endmodule

// File: branch_jump.sv
module branch_jump
   import isa_pkg::*, ctrl_pkg::*;
(
   input  br_kind_t          br_kind,
   input  logic [data_w-1:0] rs_data,
   input  logic [data_w-1:0] pc,
   input  logic [data_w-1:0] imm,
   output logic              taken,
   output logic [data_w-1:0] target,
   output logic [data_w-1:0] link_data
);

   logic [data_w-1:0] pc_next;
   logic              is_zero;
   logic              is_neg;

   // address of the next sequential instruction
   assign pc_next = pc + data_w'(2);

   assign is_zero = (rs_data == '0);
   assign is_neg  = rs_data[data_w-1];

   always_comb begin
      case (br_kind)
         BR_BEQZ: taken = is_zero;
         BR_BNEZ: taken = !is_zero;
         BR_BLTZ: taken = is_neg;
         BR_BGEZ: taken = !is_neg;
         BR_JREL: taken = 1'b1;
         BR_JREG: taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   // register jumps are based on rs, everything else is pc relative
   assign target = (br_kind == BR_JREG) ? rs_data + imm : pc_next + imm;

   assign link_data = pc_next;

endmodule

// File: regfile_bypass.sv
module regfile_bypass
   import isa_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [reg_sel_w-1:0] rd1_sel,
   input  logic [reg_sel_w-1:0] rd2_sel,
   input  logic [reg_sel_w-1:0] wr_sel,
   input  logic [data_w-1:0]    wr_data,
   input  logic                 wr_en,
   output logic [data_w-1:0]    rd1_data,
   output logic [data_w-1:0]    rd2_data
);

   logic [data_w-1:0] regs [num_regs];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < num_regs; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // a read of the register being written sees the new value this cycle
   always_comb begin
      if (wr_en && (wr_sel == rd1_sel)) begin
         rd1_data = wr_data;
      end else begin
         rd1_data = regs[rd1_sel];
      end
   end

   always_comb begin
      if (wr_en && (wr_sel == rd2_sel)) begin
         rd2_data = wr_data;
      end else begin
         rd2_data = regs[rd2_sel];
      end
   end

   // writeback must never load an unknown value into the array
   a_wr_data_known: assert property (
      @(posedge clk) disable iff (!rst_n)
      wr_en |-> !$isunknown(wr_data)
   ) else $error("regfile_bypass: unknown write data to r%0d", wr_sel);

endmodule

// File: hazard_det.sv
module hazard_det
   import isa_pkg::*;
(
   input  logic [reg_sel_w-1:0] rs_sel,
   input  logic [reg_sel_w-1:0] rt_sel,
   input  logic                 uses_rs,
   input  logic                 uses_rt,
   input  logic                 taken,
   hazard_if.det                hz,
   output logic                 stall,
   output logic                 flush
);

   logic ex_hit_rs;
   logic ex_hit_rt;
   logic mem_hit_rs;
   logic mem_hit_rt;
   logic rs_hazard;
   logic rt_hazard;

   // only stages that will actually write their destination count
   assign ex_hit_rs  = hz.ex_wr  && (hz.ex_rd  == rs_sel);
   assign ex_hit_rt  = hz.ex_wr  && (hz.ex_rd  == rt_sel);
   assign mem_hit_rs = hz.mem_wr && (hz.mem_rd == rs_sel);
   assign mem_hit_rt = hz.mem_wr && (hz.mem_rd == rt_sel);

   // a field the instruction ignores cannot create a dependence
   assign rs_hazard = uses_rs && (ex_hit_rs || mem_hit_rs);
   assign rt_hazard = uses_rt && (ex_hit_rt || mem_hit_rt);

   assign stall = rs_hazard || rt_hazard;

   // while stalled the branch operand may be stale, so hold off the flush
   assign flush = taken && !stall;

   // an unknown write enable or source flag leaves stall undefined
   always_comb begin
      assert final (!$isunknown({hz.ex_wr, hz.mem_wr, uses_rs, uses_rt}))
         else $error("hazard_det: unknown write enable or source flag");
   end

endmodule

// File: decode.sv
module decode
   import isa_pkg::*, ctrl_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [data_w-1:0]    inst,
   input  logic [data_w-1:0]    pc,
   input  logic                 wb_en,
   input  logic [reg_sel_w-1:0] wb_sel,
   input  logic [data_w-1:0]    wb_data,
   input  logic [reg_sel_w-1:0] ex_rd,
   input  logic                 ex_wr,
   input  logic [reg_sel_w-1:0] mem_rd,
   input  logic                 mem_wr,
   output logic [data_w-1:0]    rs_data,
   output logic [data_w-1:0]    rt_data,
   output logic [reg_sel_w-1:0] rs_sel,
   output logic [reg_sel_w-1:0] rt_sel,
   output logic [reg_sel_w-1:0] rd_sel,
   output logic [data_w-1:0]    imm,
   output alu_op_t              alu_op,
   output logic                 alu_src,
   output logic                 mem_read,
   output logic                 mem_write,
   output logic                 mem_to_reg,
   output logic                 reg_write,
   output logic                 halt,
   output logic                 excp,
   output logic                 taken,
   output logic [data_w-1:0]    target,
   output logic [data_w-1:0]    link_data,
   output logic                 stall,
   output logic                 flush
);

   ctrl_t                ctrl;
   logic                 uses_rs;
   logic                 uses_rt;
   logic [reg_sel_w-1:0] rd_fld;

   hazard_if hz ();

   assign hz.ex_rd  = ex_rd;
   assign hz.ex_wr  = ex_wr;
   assign hz.mem_rd = mem_rd;
   assign hz.mem_wr = mem_wr;

   assign rs_sel = inst[rs_lsb +: reg_sel_w];
   assign rt_sel = inst[rt_lsb +: reg_sel_w];
   assign rd_fld = inst[rd_lsb +: reg_sel_w];

   // destination travels down the pipe and comes back as wb_sel
   always_comb begin
      case (ctrl.dst_sel)
         DST_RD:  rd_sel = rd_fld;
         DST_RT:  rd_sel = rt_sel;
         DST_RS:  rd_sel = rs_sel;
         default: rd_sel = link_reg;
      endcase
   end

   assign alu_op     = ctrl.alu_op;
   assign alu_src    = ctrl.alu_src;
   assign mem_read   = ctrl.mem_read;
   assign mem_write  = ctrl.mem_write;
   assign mem_to_reg = ctrl.mem_to_reg;
   assign reg_write  = ctrl.reg_write;
   assign halt       = ctrl.halt;
   assign excp       = ctrl.excp;

   control u_control (
      .inst    (inst),
      .ctrl    (ctrl),
      .uses_rs (uses_rs),
      .uses_rt (uses_rt)
   );

   imm_extend u_imm_extend (
      .inst     (inst),
      .ext_op   (ctrl.ext_op),
      .ext_sign (ctrl.ext_sign),
      .imm      (imm)
   );

   branch_jump u_branch_jump (
      .br_kind   (ctrl.br_kind),
      .rs_data   (rs_data),
      .pc        (pc),
      .imm       (imm),
      .taken     (taken),
      .target    (target),
      .link_data (link_data)
   );

   regfile_bypass u_regfile (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd1_sel  (rs_sel),
      .rd2_sel  (rt_sel),
      .wr_sel   (wb_sel),
      .wr_data  (wb_data),
      .wr_en    (wb_en),
      .rd1_data (rs_data),
      .rd2_data (rt_data)
   );

   hazard_det u_hazard_det (
      .rs_sel  (rs_sel),
      .rt_sel  (rt_sel),
      .uses_rs (uses_rs),
      .uses_rt (uses_rt),
      .taken   (taken),
      .hz      (hz),
      .stall   (stall),
      .flush   (flush)
   );

   // link instructions must write r7 so writeback can return link_data there
   a_link_to_r7: assert property (
      @(posedge clk) disable iff (!rst_n)
      ctrl.link |-> (reg_write && (rd_sel == link_reg))
   ) else $error("decode: link instruction without a write to r7");

endmodule

// File: tb_clock.sv
module tb_clock (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk   = 1'b0;
      rst_n = 1'b0;
      // hold reset for ten full cycles
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
   end

   always #4 clk = ~clk;

endmodule

// File: tb_checker.sv
module tb_checker (
   input  logic        clk,
   input  logic        chk_en,
   input  int          test_id,
   input  logic [15:0] e_rs,
   input  logic [15:0] e_rt,
   input  logic [2:0]  e_rs_sel,
   input  logic [2:0]  e_rt_sel,
   input  logic [2:0]  e_rd_sel,
   input  logic [15:0] e_imm,
   input  logic [3:0]  e_alu,
   input  logic [7:0]  e_flags,
   input  logic [15:0] e_target,
   input  logic [15:0] e_link,
   input  logic        e_stall,
   input  logic        e_flush,
   input  logic [15:0] rs_data,
   input  logic [15:0] rt_data,
   input  logic [2:0]  rs_sel,
   input  logic [2:0]  rt_sel,
   input  logic [2:0]  rd_sel,
   input  logic [15:0] imm,
   input  logic [3:0]  alu_op,
   input  logic [7:0]  flags,
   input  logic [15:0] target,
   input  logic [15:0] link_data,
   input  logic        stall,
   input  logic        flush,
   output int          n_done,
   output int          n_fail
);

   int bad;

   initial begin
      n_done = 0;
      n_fail = 0;
   end

   task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
      if (got !== exp) begin
         $display("ERR t=%0t test %0d %s got %h expected %h", $time, test_id, name, got, exp);
         bad++;
      end
   endtask

   // outputs are combinational, so the falling edge sees them settled
   always @(negedge clk) begin
      if (chk_en) begin
         bad = 0;
         compare("rs_data", rs_data, e_rs);
         compare("rt_data", rt_data, e_rt);
         compare("rs_sel", 16'(rs_sel), 16'(e_rs_sel));
         compare("rt_sel", 16'(rt_sel), 16'(e_rt_sel));
         compare("rd_sel", 16'(rd_sel), 16'(e_rd_sel));
         compare("imm", imm, e_imm);
         compare("alu_op", 16'(alu_op), 16'(e_alu));
         compare("flags", 16'(flags), 16'(e_flags));
         compare("link_data", link_data, e_link);
         compare("stall", 16'(stall), 16'(e_stall));
         compare("flush", 16'(flush), 16'(e_flush));
         // target only matters for a taken transfer
         if (e_flags[0]) begin
            compare("target", target, e_target);
         end
         if (stall && flush) begin
            $display("ERR t=%0t test %0d stall and flush high together", $time, test_id);
            bad++;
         end
         if (bad == 0) begin
            $display("test %0d ok", test_id);
         end else begin
            $display("test %0d failed with %0d mismatches", test_id, bad);
            n_fail <= n_fail + 1;
         end
         n_done <= n_done + 1;
      end
   end

endmodule

// File: tb_decode.sv
module tb_decode;

   typedef struct {
      logic [15:0] inst;
      logic [15:0] pc;
      logic        wb_en;
      logic [2:0]  wb_sel;
      logic [15:0] wb_data;
      logic        rnd;
      logic [7:0]  hz;
      logic [2:0]  rd_sel;
      logic [15:0] imm;
      logic [3:0]  alu;
      logic [7:0]  flags;
      logic [15:0] target;
      logic        stall;
      logic        flush;
   } row_t;

   logic clk, rst_n;
   logic [15:0] inst, pc, wb_data;
   logic wb_en, ex_wr, mem_wr;
   logic [2:0] wb_sel, ex_rd, mem_rd;
   logic [15:0] rs_data, rt_data, imm, target, link_data;
   logic [2:0] rs_sel, rt_sel, rd_sel;
   logic [3:0] alu_op;
   logic alu_src, mem_read, mem_write, mem_to_reg, reg_write, halt, excp, taken;
   logic stall, flush;

   logic chk_en;
   int test_id;
   logic [15:0] e_rs, e_rt, e_target, e_link;
   logic [2:0] e_rs_sel, e_rt_sel;
   logic [2:0] e_rd_sel;
   logic [15:0] e_imm;
   logic [3:0] e_alu;
   logic [7:0] e_flags;
   logic e_stall, e_flush;
   int n_done, n_fail;

   row_t rows[$];
   logic [15:0] shadow [8];
   logic timed_out;

   tb_clock u_clock (.clk(clk), .rst_n(rst_n));

   decode uut (
      .clk(clk), .rst_n(rst_n), .inst(inst), .pc(pc),
      .wb_en(wb_en), .wb_sel(wb_sel), .wb_data(wb_data),
      .ex_rd(ex_rd), .ex_wr(ex_wr), .mem_rd(mem_rd), .mem_wr(mem_wr),
      .rs_data(rs_data), .rt_data(rt_data), .rs_sel(rs_sel), .rt_sel(rt_sel),
      .rd_sel(rd_sel), .imm(imm), .alu_op(alu_op), .alu_src(alu_src),
      .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg),
      .reg_write(reg_write), .halt(halt), .excp(excp), .taken(taken),
      .target(target), .link_data(link_data), .stall(stall), .flush(flush)
   );

   tb_checker u_checker (
      .clk(clk), .chk_en(chk_en), .test_id(test_id),
      .e_rs(e_rs), .e_rt(e_rt), .e_rs_sel(e_rs_sel), .e_rt_sel(e_rt_sel),
      .e_rd_sel(e_rd_sel), .e_imm(e_imm),
      .e_alu(e_alu), .e_flags(e_flags), .e_target(e_target), .e_link(e_link),
      .e_stall(e_stall), .e_flush(e_flush),
      .rs_data(rs_data), .rt_data(rt_data), .rs_sel(rs_sel), .rt_sel(rt_sel),
      .rd_sel(rd_sel), .imm(imm),
      .alu_op(alu_op),
      .flags({alu_src, reg_write, mem_read, mem_write, mem_to_reg, halt, excp, taken}),
      .target(target), .link_data(link_data), .stall(stall), .flush(flush),
      .n_done(n_done), .n_fail(n_fail)
   );

   task automatic add_row(input logic [15:0] i, input logic [15:0] p, input logic we,
                          input logic [2:0] ws, input logic [15:0] wd, input logic rnd,
                          input logic [7:0] hz, input logic [2:0] rd, input logic [15:0] im,
                          input logic [3:0] alu, input logic [7:0] fl, input logic [15:0] tg,
                          input logic st, input logic fs);
      row_t r;
      r = '{i, p, we, ws, wd, rnd, hz, rd, im, alu, fl, tg, st, fs};
      rows.push_back(r);
   endtask

   task automatic fill_table();
      // flags: alu_src reg_write mem_read mem_write mem_to_reg halt excp taken
      // hz: ex_rd ex_wr mem_rd mem_wr
      add_row(16'h0C20, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0E60, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0940, 16'h0000, 1, 1, 16'h0000, 1, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0A20, 16'h0000, 1, 2, 16'h0000, 1, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0CA0, 16'h0000, 1, 4, 16'h8001, 0, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0D80, 16'h0000, 1, 5, 16'h0005, 0, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0E20, 16'h0000, 1, 6, 16'h0000, 1, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0AC0, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0000, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 0, 16'h0000, 0, 8'h04, 0, 0, 0);
      add_row(16'hD94C, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 3, 16'h0000, 0, 8'h40, 0, 0, 0);
      add_row(16'hD95B, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 6, 16'h0000, 3, 8'h40, 0, 0, 0);
      add_row(16'h4556, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 2, 16'hFFF6, 0, 8'hC0, 0, 0, 0);
      add_row(16'h5576, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 3, 16'h0016, 2, 8'hC0, 0, 0, 0);
      add_row(16'h4D2B, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 1, 16'h000B, 1, 8'hC0, 0, 0, 0);
      add_row(16'h8CDF, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 6, 16'hFFFF, 0, 8'hE8, 0, 0, 0);
      add_row(16'h8443, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 2, 16'h0003, 0, 8'h90, 0, 0, 0);
      add_row(16'hC380, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 3, 16'hFF80, 4, 8'hC0, 0, 0, 0);
      add_row(16'hC27F, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 2, 16'h007F, 4, 8'hC0, 0, 0, 0);
      // branches and jumps from pc 0x0100
      add_row(16'h6310, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 4, 16'h0010, 0, 8'h01, 16'h0112, 0, 1);
      add_row(16'h6B10, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 4, 16'h0010, 0, 8'h00, 0, 0, 0);
      add_row(16'h74FC, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 7, 16'hFFFC, 0, 8'h01, 16'h00FE, 0, 1);
      add_row(16'h7CFC, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 7, 16'hFFFC, 0, 8'h00, 0, 0, 0);
      add_row(16'h7D04, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 1, 16'h0004, 0, 8'h01, 16'h0106, 0, 1);
      add_row(16'h27F0, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 7, 16'hFFF0, 0, 8'h01, 16'h00F2, 0, 1);
      add_row(16'h3020, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 7, 16'h0020, 0, 8'h41, 16'h0122, 0, 1);
      add_row(16'h2D08, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 7, 16'h0008, 0, 8'h01, 16'h000D, 0, 1);
      add_row(16'h3C02, 16'h0100, 0, 0, 16'h0000, 0, 8'h00, 7, 16'h0002, 0, 8'h41, 16'h8003, 0, 1);
      add_row(16'hF800, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 0, 16'h0000, 0, 8'h02, 0, 0, 0);
      // hazards against ex and mem
      add_row(16'hD94C, 16'h0000, 0, 0, 16'h0000, 0, 8'h30, 3, 16'h0000, 0, 8'h40, 0, 1, 0);
      add_row(16'hD94C, 16'h0000, 0, 0, 16'h0000, 0, 8'h20, 3, 16'h0000, 0, 8'h40, 0, 0, 0);
      add_row(16'hD94C, 16'h0000, 0, 0, 16'h0000, 0, 8'h05, 3, 16'h0000, 0, 8'h40, 0, 1, 0);
      add_row(16'hD94C, 16'h0000, 0, 0, 16'h0000, 0, 8'h07, 3, 16'h0000, 0, 8'h40, 0, 0, 0);
      add_row(16'h4556, 16'h0000, 0, 0, 16'h0000, 0, 8'h05, 2, 16'hFFF6, 0, 8'hC0, 0, 0, 0);
      add_row(16'h8443, 16'h0000, 0, 0, 16'h0000, 0, 8'h50, 2, 16'h0003, 0, 8'h90, 0, 1, 0);
      add_row(16'h6310, 16'h0100, 0, 0, 16'h0000, 0, 8'h70, 4, 16'h0010, 0, 8'h01, 16'h0112, 1, 0);
      add_row(16'hC380, 16'h0000, 0, 0, 16'h0000, 0, 8'h70, 3, 16'hFF80, 4, 8'hC0, 0, 0, 0);
      // same-cycle write of r3 seen on both ports, then read back
      add_row(16'h0B60, 16'h0000, 1, 3, 16'h0000, 1, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
      add_row(16'h0B00, 16'h0000, 0, 0, 16'h0000, 0, 8'h00, 0, 16'h0000, 0, 8'h00, 0, 0, 0);
   endtask

   // expected register read under the write-through rule
   function automatic logic [15:0] read_model(input logic [2:0] sel, input row_t r,
                                              input logic [15:0] wd);
      if (r.wb_en && (r.wb_sel == sel)) begin
         return wd;
      end
      return shadow[sel];
   endfunction

   initial begin
      row_t r;
      logic [15:0] wd;
      int waited;

      inst = 16'h0800;
      pc = '0;
      wb_en = 1'b0;
      wb_sel = '0;
      wb_data = '0;
      ex_rd = '0;
      ex_wr = 1'b0;
      mem_rd = '0;
      mem_wr = 1'b0;
      chk_en = 1'b0;
      test_id = 0;
      {e_rs, e_rt, e_target, e_link, e_rd_sel, e_imm, e_alu, e_flags} = '0;
      e_rs_sel = '0;
      e_rt_sel = '0;
      e_stall = 1'b0;
      e_flush = 1'b0;
      timed_out = 1'b0;
      void'($urandom(32'h7706_4ad8));
      for (int k = 0; k < 8; k++) begin
         shadow[k] = '0;
      end
      fill_table();

      waited = 0;
      while (rst_n !== 1'b1 && waited < 100) begin
         @(posedge clk);
         waited++;
      end
      if (rst_n !== 1'b1) begin
         $display("reset never released");
         timed_out = 1'b1;
      end
      @(posedge clk);

      for (int i = 0; i < rows.size() && !timed_out; i++) begin
         r = rows[i];
         wd = r.rnd ? 16'($urandom) : r.wb_data;
         inst <= r.inst;
         pc <= r.pc;
         wb_en <= r.wb_en;
         wb_sel <= r.wb_sel;
         wb_data <= wd;
         {ex_rd, ex_wr, mem_rd, mem_wr} <= r.hz;
         chk_en <= 1'b1;
         test_id <= i;
         e_rs <= read_model(r.inst[10:8], r, wd);
         e_rt <= read_model(r.inst[7:5], r, wd);
         e_rs_sel <= r.inst[10:8];
         e_rt_sel <= r.inst[7:5];
         e_rd_sel <= r.rd_sel;
         e_imm <= r.imm;
         e_alu <= r.alu;
         e_flags <= r.flags;
         e_target <= r.target;
         e_link <= r.pc + 16'd2;
         e_stall <= r.stall;
         e_flush <= r.flush;
         waited = 0;
         while (n_done <= i && waited < 20) begin
            @(posedge clk);
            waited++;
         end
         if (n_done <= i) begin
            $display("checker gave no result for test %0d", i);
            timed_out = 1'b1;
         end
         if (r.wb_en) begin
            shadow[r.wb_sel] = wd;
         end
      end
      chk_en <= 1'b0;
      wb_en <= 1'b0;

      $display("tests %0d, failed %0d", n_done, n_fail);
      if (timed_out || n_fail != 0) begin
         $display("STATUS: FAIL");
      end else begin
         $display("STATUS: PASS");
      end
      $finish;
   end

endmodule

// File: decode_stage.f
isa_pkg.sv
ctrl_pkg.sv
hazard_if.sv
control.sv
imm_extend.sv
branch_jump.sv
regfile_bypass.sv
hazard_det.sv
decode.sv
tb_clock.sv
tb_checker.sv
tb_decode.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode -f decode_stage.f -o sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

output=$(./obj_dir/sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q "^STATUS: PASS$"; then
   exit 0
fi
exit 1
